/* Bender.yml */
package:
  name: cache

sources:
  - logic/cache_pkg.sv
  - logic/mem_burst_if.sv
  - logic/cache_store.sv
  - logic/cache_controller.sv
  - logic/line_fill_buffer.sv
  - logic/mem_burst_port.sv
  - logic/cache_top.sv
  - target: test
    files:
      - tests/cache_asserts.sv
      - tests/cache_tb.sv

/* logic/cache_controller.sv */
`timescale 1ns/1ps

module cache_controller (
  input  logic                     clock,
  input  logic                     reset_n,
  input  cache_pkg::addr_t         cpu_addr,
  input  logic                     cpu_rd,
  input  logic                     cpu_wr,
  input  cache_pkg::be_t           cpu_wr_be,
  input  cache_pkg::word_t         cpu_wr_data,
  output logic                     cpu_rd_valid,
  output cache_pkg::word_t         cpu_rd_data,
  output logic                     cpu_waitrequest,
  input  logic                     line_full,
  input  cache_pkg::line_t         fill_line,
  output logic                     fill_clear,
  mem_burst_if.controller          bus
);
  import cache_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_writeback,
    st_fill
  } state_t;

  state_t     state;
  state_t     next_state;
  logic       req;
  logic       hit;
  logic       serve;
  logic       victim_dirty;
  way_t       victim_way;
  tag_entry_t victim_entry;
  line_t      victim_line;
  way_t       way_q;
  index_t     index_q;
  logic       install_en;
  logic       victim_mark_clean;

  cache_store u_store (
    .clock             (clock),
    .reset_n           (reset_n),
    .lookup_addr       (cpu_addr),
    .cpu_write_en      (cpu_wr && serve),
    .write_be          (cpu_wr_be),
    .write_data        (cpu_wr_data),
    .install_en        (install_en),
    .install_way       (way_q),
    .install_index     (index_q),
    .install_tag       (addr_tag(cpu_addr)),
    .install_line      (fill_line),
    .victim_mark_clean (victim_mark_clean),
    .lfsr_step         (install_en),
    .hit               (hit),
    .hit_word          (cpu_rd_data),
    .victim_way        (victim_way),
    .victim_entry      (victim_entry),
    .victim_line       (victim_line)
  );

  assign req             = cpu_rd || cpu_wr;
  assign serve           = (state == st_idle) && hit;
  assign cpu_rd_valid    = cpu_rd && serve;
  assign cpu_waitrequest = req && !serve;
  assign victim_dirty    = victim_entry.valid && victim_entry.dirty;

  // victim stays put through the writeback, lfsr only moves at install
  assign bus.wr_line   = victim_line;
  assign bus.line_addr = (state == st_idle && victim_dirty)
                         ? line_base(victim_entry.tag, addr_index(cpu_addr))
                         : line_base(addr_tag(cpu_addr), addr_index(cpu_addr));

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state <= st_idle;
    end else begin
      state <= next_state;
    end
  end

  always_ff @(posedge clock) begin
    if (state == st_idle && req && !hit) begin
      way_q   <= victim_way;
      index_q <= addr_index(cpu_addr);
    end
  end

  always_comb begin
    next_state        = state;
    bus.rd_start      = 1'b0;
    bus.wr_start      = 1'b0;
    install_en        = 1'b0;
    victim_mark_clean = 1'b0;
    fill_clear        = 1'b0;
    case (state)
      st_idle: begin
        if (req && !hit) begin
          if (victim_dirty) begin
            bus.wr_start = 1'b1;
            next_state   = st_writeback;
          end else begin
            bus.rd_start = 1'b1;
            next_state   = st_fill;
          end
        end
      end
      st_writeback: begin
        if (bus.wr_done) begin
          victim_mark_clean = 1'b1;
          bus.rd_start      = 1'b1;
          next_state        = st_fill;
        end
      end
      st_fill: begin
        if (line_full) begin
          install_en = 1'b1;   // lookup hits the cycle after
          fill_clear = 1'b1;
          next_state = st_idle;
        end
      end
      default: next_state = st_idle;
    endcase
  end

endmodule

/* logic/cache_pkg.sv */
package cache_pkg;

  localparam int addr_width     = 16;
  localparam int data_width     = 32;
  localparam int be_width       = 4;
  localparam int mem_data_width = 32;
  localparam int line_words     = 4;
  localparam int line_width     = 128;
  localparam int num_sets       = 16;
  localparam int num_ways       = 4;
  localparam int offset_width   = 4;
  localparam int index_width    = 4;
  localparam int tag_width      = 8;

  localparam logic [10:0] lfsr_seed = 11'd101;

  typedef logic [addr_width-1:0]  addr_t;
  typedef logic [data_width-1:0]  word_t;
  typedef logic [be_width-1:0]    be_t;
  typedef logic [line_width-1:0]  line_t;
  typedef logic [tag_width-1:0]   tag_t;
  typedef logic [index_width-1:0] index_t;
  typedef logic [1:0]             way_t;
  typedef logic [1:0]             beat_t;

  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_entry_t;

  // address is tag | index | word | byte
  function automatic tag_t addr_tag(addr_t a);
    return a[addr_width-1 -: tag_width];
  endfunction

  function automatic index_t addr_index(addr_t a);
    return a[offset_width +: index_width];
  endfunction

  function automatic beat_t addr_word(addr_t a);
    return a[offset_width-1:2];
  endfunction

  function automatic addr_t line_base(tag_t t, index_t i);
    return {t, i, {offset_width{1'b0}}};
  endfunction

endpackage

/* logic/cache_store.sv */
`timescale 1ns/1ps

module cache_store (
  input  logic                   clock,
  input  logic                   reset_n,
  input  cache_pkg::addr_t       lookup_addr,
  input  logic                   cpu_write_en,
  input  cache_pkg::be_t         write_be,
  input  cache_pkg::word_t       write_data,
  input  logic                   install_en,
  input  cache_pkg::way_t        install_way,
  input  cache_pkg::index_t      install_index,
  input  cache_pkg::tag_t        install_tag,
  input  cache_pkg::line_t       install_line,
  input  logic                   victim_mark_clean,
  input  logic                   lfsr_step,
  output logic                   hit,
  output cache_pkg::word_t       hit_word,
  output cache_pkg::way_t        victim_way,
  output cache_pkg::tag_entry_t  victim_entry,
  output cache_pkg::line_t       victim_line
);
  import cache_pkg::*;

  tag_entry_t          tags [num_ways][num_sets];
  line_t               data [num_ways][num_sets];
  logic [10:0]         lfsr;
  logic [num_ways-1:0] way_hit;
  way_t                hit_way;
  way_t                rand_way;
  index_t              idx;
  tag_t                tag;
  beat_t               word_sel;
  word_t               be_mask;
  word_t               merged;

  assign idx      = addr_index(lookup_addr);
  assign tag      = addr_tag(lookup_addr);
  assign word_sel = addr_word(lookup_addr);

  // x^11 + x^9 + 1, stepped two bits at a time
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      lfsr <= lfsr_seed;
    end else if (lfsr_step) begin
      lfsr <= {lfsr[1] ^ lfsr[3], lfsr[0] ^ lfsr[2], lfsr[10:2]};
    end
  end

  assign rand_way = lfsr[1:0];

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < num_ways; w++) begin
      way_hit[w] = tags[w][idx].valid && (tags[w][idx].tag == tag);
      if (way_hit[w]) hit_way = way_t'(w);
    end
  end

  assign hit      = |way_hit;
  assign hit_word = data[hit_way][idx][word_sel*data_width +: data_width];

  always_comb begin
    for (int b = 0; b < be_width; b++) begin
      be_mask[b*8 +: 8] = {8{write_be[b]}};
    end
  end

  assign merged = (hit_word & ~be_mask) | (write_data & be_mask);

  // free way, then clean way after the random start, then random
  always_comb begin
    logic found;
    way_t probe;
    found      = 1'b0;
    victim_way = rand_way;
    for (int w = 0; w < num_ways; w++) begin
      if (!found && !tags[w][idx].valid) begin
        victim_way = way_t'(w);
        found      = 1'b1;
      end
    end
    for (int k = 1; k <= num_ways; k++) begin
      probe = rand_way + way_t'(k);   // wraps back to rand_way last
      if (!found && !tags[probe][idx].dirty) begin
        victim_way = probe;
        found      = 1'b1;
      end
    end
  end

  assign victim_entry = tags[victim_way][idx];
  assign victim_line  = data[victim_way][idx];

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      for (int w = 0; w < num_ways; w++) begin
        for (int s = 0; s < num_sets; s++) begin
          tags[w][s] <= '0;
        end
      end
    end else if (install_en) begin
      tags[install_way][install_index] <= '{valid: 1'b1, dirty: 1'b0, tag: install_tag};
    end else if (victim_mark_clean) begin
      tags[install_way][install_index].dirty <= 1'b0;  // memory has it now
    end else if (cpu_write_en) begin
      tags[hit_way][idx].dirty <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (install_en) begin
      data[install_way][install_index] <= install_line;
    end else if (cpu_write_en) begin
      data[hit_way][idx][word_sel*data_width +: data_width] <= merged;
    end
  end

endmodule

/* logic/cache_top.sv */
`timescale 1ns/1ps

module cache_top (
  input  logic              clock,
  input  logic              reset_n,
  input  cache_pkg::addr_t  cpu_addr,
  input  logic              cpu_rd,
  input  logic              cpu_wr,
  input  cache_pkg::be_t    cpu_wr_be,
  input  cache_pkg::word_t  cpu_wr_data,
  output logic              cpu_rd_valid,
  output cache_pkg::word_t  cpu_rd_data,
  output logic              cpu_waitrequest,
  output cache_pkg::addr_t  mem_addr,
  output cache_pkg::beat_t  mem_burst_len,
  output cache_pkg::word_t  mem_wr_data,
  output logic              mem_wr,
  output logic              mem_rd,
  input  cache_pkg::word_t  mem_rd_data,
  input  logic              mem_rd_valid,
  input  logic              mem_waitrequest
);
  import cache_pkg::*;

  logic  line_full;
  logic  fill_clear;
  line_t fill_line;

  mem_burst_if mem_bus ();

  assign mem_burst_len = beat_t'(line_words - 1);  // zero means one beat

  cache_controller u_ctrl (
    .clock           (clock),
    .reset_n         (reset_n),
    .cpu_addr        (cpu_addr),
    .cpu_rd          (cpu_rd),
    .cpu_wr          (cpu_wr),
    .cpu_wr_be       (cpu_wr_be),
    .cpu_wr_data     (cpu_wr_data),
    .cpu_rd_valid    (cpu_rd_valid),
    .cpu_rd_data     (cpu_rd_data),
    .cpu_waitrequest (cpu_waitrequest),
    .line_full       (line_full),
    .fill_line       (fill_line),
    .fill_clear      (fill_clear),
    .bus             (mem_bus)
  );

  line_fill_buffer u_fill (
    .clock      (clock),
    .reset_n    (reset_n),
    .fill_clear (fill_clear),
    .bus        (mem_bus),
    .line_full  (line_full),
    .fill_line  (fill_line)
  );

  mem_burst_port u_port (
    .clock           (clock),
    .reset_n         (reset_n),
    .mem_rd_data     (mem_rd_data),
    .mem_rd_valid    (mem_rd_valid),
    .mem_waitrequest (mem_waitrequest),
    .bus             (mem_bus),
    .mem_addr        (mem_addr),
    .mem_wr_data     (mem_wr_data),
    .mem_wr          (mem_wr),
    .mem_rd          (mem_rd)
  );

endmodule

/* logic/line_fill_buffer.sv */
`timescale 1ns/1ps

module line_fill_buffer (
  input  logic             clock,
  input  logic             reset_n,
  input  logic             fill_clear,
  mem_burst_if.fill        bus,
  output logic             line_full,
  output cache_pkg::line_t fill_line
);
  import cache_pkg::*;

  logic [line_words-1:0] beat_valid;
  beat_t                 fill_ptr;   // fills always start at word 0

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      beat_valid <= '0;
      fill_ptr   <= '0;
    end else if (fill_clear) begin
      beat_valid <= '0;
      fill_ptr   <= '0;
    end else if (bus.rd_word_valid) begin
      beat_valid[fill_ptr] <= 1'b1;
      fill_ptr             <= fill_ptr + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (bus.rd_word_valid) begin
      fill_line[fill_ptr*data_width +: data_width] <= bus.rd_word;
    end
  end

  assign line_full = &beat_valid;

endmodule

/* logic/mem_burst_if.sv */
`timescale 1ns/1ps

interface mem_burst_if;
  import cache_pkg::*;

  logic  rd_start;      // pulse, start a line fill
  logic  wr_start;      // pulse, start a victim writeback
  addr_t line_addr;
  line_t wr_line;
  logic  wr_done;
  word_t rd_word;
  logic  rd_word_valid;

  modport controller (
    output rd_start, wr_start, line_addr, wr_line,
    input  wr_done
  );

  modport port (
    input  rd_start, wr_start, line_addr, wr_line,
    output wr_done, rd_word, rd_word_valid
  );

  modport fill (
    input rd_word, rd_word_valid
  );

endinterface

/* logic/mem_burst_port.sv */
`timescale 1ns/1ps

module mem_burst_port (
  input  logic             clock,
  input  logic             reset_n,
  input  cache_pkg::word_t mem_rd_data,
  input  logic             mem_rd_valid,
  input  logic             mem_waitrequest,
  mem_burst_if.port        bus,
  output cache_pkg::addr_t mem_addr,
  output cache_pkg::word_t mem_wr_data,
  output logic             mem_wr,
  output logic             mem_rd
);
  import cache_pkg::*;

  beat_t wr_beat;
  beat_t beat_sel;
  logic  beat_accept;
  logic  last_beat;

  assign beat_accept = mem_wr && !mem_waitrequest;
  assign last_beat   = (wr_beat == beat_t'(line_words - 1));
  assign beat_sel    = bus.wr_start ? '0 : wr_beat + 1'b1;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      mem_rd      <= 1'b0;
      mem_wr      <= 1'b0;
      wr_beat     <= '0;
      bus.wr_done <= 1'b0;
    end else begin
      bus.wr_done <= 1'b0;
      if (bus.rd_start) begin
        mem_rd <= 1'b1;
      end else if (mem_rd && !mem_waitrequest) begin
        mem_rd <= 1'b0;   // command taken
      end
      if (bus.wr_start) begin
        mem_wr  <= 1'b1;
        wr_beat <= '0;
      end else if (beat_accept) begin
        if (last_beat) begin
          mem_wr      <= 1'b0;
          bus.wr_done <= 1'b1;
        end else begin
          wr_beat <= wr_beat + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (bus.rd_start || bus.wr_start) begin
      mem_addr <= bus.line_addr;
    end else if (beat_accept && !last_beat) begin
      mem_addr <= mem_addr + addr_t'(mem_data_width / 8);
    end
    if (bus.wr_start || (beat_accept && !last_beat)) begin
      mem_wr_data <= bus.wr_line[beat_sel*mem_data_width +: mem_data_width];
    end
  end

  // read beats go straight to the fill buffer
  assign bus.rd_word       = mem_rd_data;
  assign bus.rd_word_valid = mem_rd_valid;

endmodule

/* project.f */
logic/cache_pkg.sv
logic/mem_burst_if.sv
logic/cache_store.sv
logic/cache_controller.sv
logic/line_fill_buffer.sv
logic/mem_burst_port.sv
logic/cache_top.sv
tests/cache_asserts.sv
tests/cache_tb.sv

/* tests/cache_asserts.sv */
`timescale 1ns/1ps

module cache_asserts (
  input logic             clock,
  input logic             reset_n,
  input logic             cpu_rd_valid,
  input logic             cpu_waitrequest,
  input logic             mem_rd,
  input logic             mem_wr,
  input logic             mem_waitrequest,
  input cache_pkg::addr_t mem_addr
);

  int unsigned fail_count = 0;

  // read data only in a served cycle with no burst open
  rd_valid_when_served: assert property (
    @(posedge clock) disable iff (!reset_n)
      cpu_rd_valid |-> !cpu_waitrequest && !mem_rd && !mem_wr
  ) else begin
    fail_count++;
    $error("cpu_rd_valid high while the CPU is stalled or a burst is open");
  end

  one_burst_direction: assert property (
    @(posedge clock) disable iff (!reset_n) !(mem_rd && mem_wr)
  ) else begin
    fail_count++;
    $error("mem_rd and mem_wr high together");
  end

  // command address holds while the slave stalls it
  rd_addr_stable: assert property (
    @(posedge clock) disable iff (!reset_n) mem_rd && mem_waitrequest |=> $stable(mem_addr)
  ) else begin
    fail_count++;
    $error("mem_addr changed while mem_rd was stalled");
  end

endmodule

bind cache_top cache_asserts u_asserts (.*);

/* tests/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb;
  import cache_pkg::*;

  localparam int clock_period = 100;
  localparam int reset_cycles = 8;
  localparam int num_ops      = 600;
  localparam int sweep_ops    = 64 * line_words;
  localparam int watchdog_ns  = (reset_cycles + num_ops + sweep_ops) * 400 * clock_period;

  logic  clock;
  logic  reset_n;
  addr_t cpu_addr;
  logic  cpu_rd;
  logic  cpu_wr;
  be_t   cpu_wr_be;
  word_t cpu_wr_data;
  logic  cpu_rd_valid;
  word_t cpu_rd_data;
  logic  cpu_waitrequest;
  addr_t mem_addr;
  beat_t mem_burst_len;
  word_t mem_wr_data;
  logic  mem_wr;
  logic  mem_rd;
  word_t mem_rd_data;
  logic  mem_rd_valid;
  logic  mem_waitrequest;

  word_t       model   [addr_t];   // what the CPU should see
  word_t       backing [addr_t];   // memory behind the cache
  int unsigned cpu_seed = 32'd72737;
  int unsigned mem_seed;
  int          wb_beat = 0;
  addr_t       wb_base;
  int          rd_left = 0;
  addr_t       rd_addr;

  cache_top DUT (.*);

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  function automatic int unsigned next_rand(input int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // tag is the line number so even sets get six lines and odd sets two
  function automatic addr_t line_addr_of(input int k);
    logic [5:0] n;
    n = k[5:0];
    return {2'b00, n, n[3:1], n[0] & n[4], 4'b0000};
  endfunction

  function automatic word_t init_word(input addr_t a);
    return {a ^ 16'hc3a5, ~a};
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_beat(input beat_t got, input beat_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0t %s: got %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  // one CPU request held until cpu_waitrequest is low at a falling edge
  task automatic run_op(input logic is_write, input addr_t a, input be_t be, input word_t d,
                        input logic repeat_read);
    word_t merged;
    @(posedge clock);
    cpu_addr    <= a;
    cpu_rd      <= !is_write;
    cpu_wr      <= is_write;
    cpu_wr_be   <= be;
    cpu_wr_data <= d;
    @(negedge clock);
    if (repeat_read && cpu_waitrequest) begin
      abort_run($sformatf("Repeated read of address %h stalled in its request cycle", a));
    end
    while (cpu_waitrequest) @(negedge clock);
    if (is_write) begin
      merged = model[a];
      for (int b = 0; b < be_width; b++) begin
        if (be[b]) merged[b*8 +: 8] = d[b*8 +: 8];
      end
      model[a] = merged;
    end else begin
      if (!cpu_rd_valid) begin
        abort_run($sformatf("Read of address %h completed without cpu_rd_valid", a));
      end
      check_word(cpu_rd_data, model[a], $sformatf("read data at %h", a));
    end
  endtask

  // memory slave with random wait states
  always @(posedge clock) begin
    mem_seed = next_rand(mem_seed);
    if (!reset_n) begin
      mem_waitrequest <= 1'b0;
      mem_rd_valid    <= 1'b0;
    end else begin
      mem_waitrequest <= (mem_seed[17:16] == 2'b00);  // one cycle in four
      mem_rd_valid    <= 1'b0;
      if (mem_wr && !mem_waitrequest) begin
        if (wb_beat == 0) begin
          check_addr(mem_addr, {mem_addr[15:4], 4'h0}, "writeback base");
          wb_base = mem_addr;
        end
        check_addr(mem_addr, wb_base + addr_t'(4 * wb_beat), "writeback beat address");
        backing[mem_addr] = mem_wr_data;
        wb_beat++;
        if (wb_beat == line_words) begin
          wb_beat = 0;
          // whole victim line must hold what the CPU wrote
          for (int w = 0; w < line_words; w++) begin
            check_word(backing[wb_base + addr_t'(4 * w)], model[wb_base + addr_t'(4 * w)],
                       "written back line");
          end
        end
      end
      if (mem_rd && !mem_waitrequest) begin
        if (wb_beat != 0 || rd_left != 0) begin
          abort_run("Read burst started while another burst was still open");
        end
        check_addr(mem_addr, {cpu_addr[15:4], 4'h0}, "read burst address");
        rd_addr = mem_addr;
        rd_left = line_words;
        check_beat(mem_burst_len, beat_t'(rd_left - 1), "burst length");
      end else if (rd_left != 0 && mem_seed[20:19] != 2'b00) begin
        mem_rd_valid <= 1'b1;
        mem_rd_data  <= backing[rd_addr];
        rd_addr      = rd_addr + addr_t'(4);
        rd_left--;
      end
    end
  end

  initial begin
    #(watchdog_ns);
    abort_run("Timeout: the cache did not finish the test in the expected time");
  end

  initial begin
    int unsigned r;
    addr_t       a;
    addr_t       last_rd;
    logic        last_was_read;
    logic        is_write;
    reset_n         = 1'b0;
    cpu_addr        = '0;
    cpu_rd          = 1'b0;
    cpu_wr          = 1'b0;
    cpu_wr_be       = '0;
    cpu_wr_data     = '0;
    mem_rd_data     = '0;
    mem_rd_valid    = 1'b0;
    mem_waitrequest = 1'b0;
    mem_seed        = ~cpu_seed;
    last_rd         = '0;
    last_was_read   = 1'b0;
    for (int k = 0; k < 64; k++) begin
      for (int w = 0; w < line_words; w++) begin
        a          = line_addr_of(k) + addr_t'(4 * w);
        model[a]   = init_word(a);
        backing[a] = init_word(a);
      end
    end
    repeat (reset_cycles) @(posedge clock);
    reset_n <= 1'b1;

    for (int i = 0; i < num_ops; i++) begin
      cpu_seed = next_rand(cpu_seed);
      r        = cpu_seed >> 8;
      if (last_was_read && r[3:0] < 4'd4) begin
        run_op(1'b0, last_rd, '0, '0, 1'b1);  // same address again
      end else begin
        a        = line_addr_of(int'(r[9:4])) + addr_t'(4 * r[11:10]);
        is_write = r[12];
        cpu_seed = next_rand(cpu_seed);
        run_op(is_write, a, be_t'(r[16:13]), cpu_seed, 1'b0);
        last_was_read = !is_write;
        last_rd       = a;
      end
    end

    // final sweep over every word of every line
    for (int k = 0; k < 64; k++) begin
      for (int w = 0; w < line_words; w++) begin
        run_op(1'b0, line_addr_of(k) + addr_t'(4 * w), '0, '0, 1'b0);
      end
    end
    @(posedge clock);
    cpu_rd <= 1'b0;
    cpu_wr <= 1'b0;
    repeat (4) @(posedge clock);

    if (DUT.u_asserts.fail_count == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("%0d protocol assertions failed", DUT.u_asserts.fail_count);
      $display("Simulation failed");
      $fatal(1, "run ended with errors");
    end
  end

endmodule
